/* src/dab_settings.svh */
`ifndef DAB_SETTINGS_SVH
`define DAB_SETTINGS_SVH

////////////////////////////// widths
`define DAB_VIN_W      14            // raw voltage counts, signed
`define DAB_FS_W       19            // switching frequency in Hz, signed
`define DAB_ANG_W      9             // output angle, signed
`define DAB_QUOT_BITS  16            // quotient magnitude bits
`define DAB_FRAC_BITS  4             // quotient lsb = 2^-4 output step
`define DAB_OUT_MAX    255           // angle clamp, +-255 = +-pi

////////////////////////////// gains
// volts = count * 1000/8192; num and den both carry the 8192
`define DAB_K_TAU_V1   4080000       // 255 * 16 * 1000
`define DAB_K_TAU_FS   6685          // 1020 * L * Ipc * 16 * 8192, L = 25u, Ipc = 2
`define DAB_K_TAU_V2   5500          // n1/n2 = 5.5, times 1000
`define DAB_K_PHI_FS   3950          // 510 * L * (Ipc + Isc*n2/n1) * 16 * 8192
`define DAB_K_PHI_V1   1000          // count to volt, times 8192

////////////////////////////// timing
`define DAB_LATENCY    (2 + `DAB_QUOT_BITS)  // trigger edge to out_valid

`endif

/* src/dab_pkg.sv */
`include "dab_settings.svh"

package dab_pkg;

  ////////////////////////////// inputs
  typedef logic signed [`DAB_VIN_W-1:0] vin_t;        // dc link count
  typedef logic signed [`DAB_FS_W-1:0]  fs_t;         // switching freq

  ////////////////////////////// results
  typedef logic signed [`DAB_ANG_W-1:0] angle_t;      // scaled by 255/pi
  typedef logic signed [`DAB_QUOT_BITS:0] quot_t;     // sign + magnitude bits

  ////////////////////////////// divider operands
  typedef logic [31:0]        den_t;                  // always positive
  typedef logic signed [39:0] tau_num_t;              // v1 term minus fs term
  typedef logic signed [35:0] phi_num_t;              // fs term only

endpackage

/* src/serial_divider.sv */
`timescale 1ns/1ps
`include "dab_settings.svh"

module serial_divider #(
  parameter type num_t = dab_pkg::tau_num_t
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  num_t           numer,
  input  dab_pkg::den_t  denom,
  output dab_pkg::quot_t quot,
  output logic           done
);

  localparam int QB    = `DAB_QUOT_BITS;
  localparam int STEPS = QB + 1;                              // extra step flags overflow
  localparam int NUM_W = $bits(num_t);
  localparam int DSR_W = $bits(dab_pkg::den_t) + QB;
  localparam int W     = (NUM_W > DSR_W) ? NUM_W : DSR_W;     // common compare width

  logic                       busy;
  logic [$clog2(STEPS)-1:0]   cnt;                            // step index
  logic                       last;
  logic                       neg;                            // result sign
  logic [W-1:0]               rem;                            // partial remainder
  logic [W-1:0]               dsr;                            // shifted divisor
  logic [QB-1:0]              q_acc;
  logic [QB:0]                q_next;
  logic                       ge;
  logic [QB-1:0]              mag_sat;
  logic [NUM_W-1:0]           numer_mag;
  logic                       accept;

  assign accept    = start & ~busy;                           // start while busy is dropped
  assign numer_mag = numer[NUM_W-1] ? NUM_W'(-numer) : NUM_W'(numer);
  assign last      = (cnt == STEPS-1);
  assign ge        = (rem >= dsr);
  assign q_next    = {q_acc, ge};                             // msb first
  assign mag_sat   = q_next[QB] ? '1 : q_next[QB-1:0];        // top bit set means >= 2^QB

  ////////////////////////////// control
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;                                           // single cycle pulse
      if (accept)
      begin
        busy <= 1'b1;
        cnt  <= '0;
      end
      else if (busy)
      begin
        cnt <= cnt + 1'b1;
        if (last)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////// datapath
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rem   <= W'(numer_mag);
      dsr   <= W'({denom, {QB{1'b0}}});                       // divisor * 2^QB
      neg   <= numer[NUM_W-1];
      q_acc <= '0;
    end
    else if (busy)
    begin
      if (ge)
        rem <= rem - dsr;                                     // restore by not subtracting
      dsr   <= dsr >> 1;
      q_acc <= q_next[QB-1:0];
      if (last)
        quot <= neg ? -dab_pkg::quot_t'({1'b0, mag_sat}) : dab_pkg::quot_t'({1'b0, mag_sat});
    end
  end

  // a zero divisor would saturate silently
  a_den_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    accept |-> (denom != '0));

  // done follows an accepted start after the full step count
  a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
    accept |-> ##(STEPS+1) done);

endmodule

/* src/duty_branch.sv */
`timescale 1ns/1ps
`include "dab_settings.svh"

module duty_branch (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           trigger,
  input  dab_pkg::vin_t  vdc1,
  input  dab_pkg::vin_t  vdc2,
  input  dab_pkg::fs_t   fs_dab,
  output dab_pkg::quot_t tau_quot,
  output logic           tau_done
);

  // mode 2b: tau2 = (pi*V1 - 4*pi*L*Ipc*fs) / (n*V2), rescaled by 255/pi
  localparam dab_pkg::tau_num_t K_V1 = `DAB_K_TAU_V1;
  localparam dab_pkg::tau_num_t K_FS = `DAB_K_TAU_FS;
  localparam dab_pkg::den_t     K_V2 = `DAB_K_TAU_V2;

  dab_pkg::tau_num_t v1_term;                                 // pi/d part
  dab_pkg::tau_num_t fs_term;                                 // c2*fs part
  dab_pkg::tau_num_t tau_num;
  dab_pkg::den_t     tau_den;                                 // secondary seen on primary

  assign v1_term = K_V1 * dab_pkg::tau_num_t'(vdc1);          // sign extended
  assign fs_term = K_FS * dab_pkg::tau_num_t'(fs_dab);
  assign tau_num = v1_term - fs_term;                         // can go negative at high fs
  assign tau_den = K_V2 * dab_pkg::den_t'(vdc2);

  serial_divider #(
    .num_t (dab_pkg::tau_num_t)
  ) u_div (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (trigger),
    .numer  (tau_num),
    .denom  (tau_den),
    .quot   (tau_quot),
    .done   (tau_done)
  );

endmodule

/* src/phase_branch.sv */
`timescale 1ns/1ps
`include "dab_settings.svh"

module phase_branch (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           trigger,
  input  dab_pkg::vin_t  vdc1,
  input  dab_pkg::fs_t   fs_dab,
  output dab_pkg::quot_t phi_quot,
  output logic           phi_done
);

  // mode 2a: phi = c1*fs/V1, c1 = -2*pi*L*(Ipc + Isc*n2/n1)
  localparam dab_pkg::phi_num_t K_FS = `DAB_K_PHI_FS;
  localparam dab_pkg::den_t     K_V1 = `DAB_K_PHI_V1;

  dab_pkg::phi_num_t phi_num;
  dab_pkg::den_t     phi_den;

  assign phi_num = -(K_FS * dab_pkg::phi_num_t'(fs_dab));     // c1 is negative
  assign phi_den = K_V1 * dab_pkg::den_t'(vdc1);              // primary volts, scaled

  serial_divider #(
    .num_t (dab_pkg::phi_num_t)
  ) u_div (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (trigger),
    .numer  (phi_num),
    .denom  (phi_den),
    .quot   (phi_quot),
    .done   (phi_done)
  );

  // negative primary voltage would be read as a huge unsigned divisor
  a_vdc1_pos: assert property (@(posedge clk) disable iff (!arst_n)
    trigger |-> (vdc1 > 0));

endmodule

/* src/angle_combiner.sv */
`timescale 1ns/1ps
`include "dab_settings.svh"

module angle_combiner (
  input  logic            clk,
  input  logic            arst_n,
  input  dab_pkg::quot_t  tau_quot,
  input  logic            tau_done,
  input  dab_pkg::quot_t  phi_quot,
  input  logic            phi_done,
  output dab_pkg::angle_t tau2,
  output dab_pkg::angle_t phi_2b,
  output dab_pkg::angle_t phi_2a,
  output logic            out_valid
);

  localparam int QB = `DAB_QUOT_BITS;
  localparam int AW = `DAB_ANG_W;

  // quotient in 2^-FRAC steps to angle, half away from zero, clamped
  function automatic dab_pkg::angle_t to_angle(input dab_pkg::quot_t q, input logic halve);
    logic [QB:0]   mag;
    logic [QB:0]   rnd;
    logic [AW-2:0] lim;
    mag = q[QB] ? $unsigned(-q) : $unsigned(q);
    if (halve)
      mag = mag >> 1;                                         // phi_2b = tau2/2, toward zero
    rnd = (mag + (QB+1)'(1 << (`DAB_FRAC_BITS-1))) >> `DAB_FRAC_BITS;
    lim = (rnd > `DAB_OUT_MAX) ? (AW-1)'(`DAB_OUT_MAX) : rnd[AW-2:0];
    return q[QB] ? -dab_pkg::angle_t'({1'b0, lim}) : dab_pkg::angle_t'({1'b0, lim});
  endfunction

  logic           tau_flag;                                   // tau quotient held
  logic           phi_flag;                                   // phi quotient held
  dab_pkg::quot_t tau_val;
  dab_pkg::quot_t phi_val;
  dab_pkg::quot_t tau_sel;
  dab_pkg::quot_t phi_sel;
  logic           fire;

  assign tau_sel = tau_done ? tau_quot : tau_val;             // bypass on arrival
  assign phi_sel = phi_done ? phi_quot : phi_val;
  assign fire    = (tau_flag | tau_done) & (phi_flag | phi_done);

  ////////////////////////////// capture
  always_ff @(posedge clk)
  begin
    if (tau_done)
      tau_val <= tau_quot;
    if (phi_done)
      phi_val <= phi_quot;
  end

  ////////////////////////////// join and output
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tau_flag  <= 1'b0;
      phi_flag  <= 1'b0;
      out_valid <= 1'b0;
      tau2      <= '0;
      phi_2b    <= '0;
      phi_2a    <= '0;
    end
    else
    begin
      out_valid <= fire;
      if (fire)
      begin
        tau_flag <= 1'b0;                                     // both consumed
        phi_flag <= 1'b0;
        tau2     <= to_angle(tau_sel, 1'b0);
        phi_2b   <= to_angle(tau_sel, 1'b1);
        phi_2a   <= to_angle(phi_sel, 1'b0);
      end
      else
      begin
        if (tau_done)
          tau_flag <= 1'b1;
        if (phi_done)
          phi_flag <= 1'b1;
      end
    end
  end

  // branches run in lockstep, a second result before the join means a lost one
  a_tau_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
    tau_done |-> !tau_flag);

  a_phi_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
    phi_done |-> !phi_flag);

endmodule

/* src/dab_modulator.sv */
`timescale 1ns/1ps

module dab_modulator (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            trigger,      // one cycle, samples inputs
  input  dab_pkg::vin_t   vdc1,         // primary dc link
  input  dab_pkg::vin_t   vdc2,         // secondary dc link
  input  dab_pkg::fs_t    fs_dab,
  output dab_pkg::angle_t tau2,
  output dab_pkg::angle_t phi_2b,
  output dab_pkg::angle_t phi_2a,
  output logic            out_valid
);

  dab_pkg::quot_t tau_quot;
  dab_pkg::quot_t phi_quot;
  logic           tau_done;
  logic           phi_done;

  duty_branch u_duty (                  // mode 2b shift angle
    .clk      (clk),
    .arst_n   (arst_n),
    .trigger  (trigger),
    .vdc1     (vdc1),
    .vdc2     (vdc2),
    .fs_dab   (fs_dab),
    .tau_quot (tau_quot),
    .tau_done (tau_done)
  );

  phase_branch u_phase (                // mode 2a phase
    .clk      (clk),
    .arst_n   (arst_n),
    .trigger  (trigger),
    .vdc1     (vdc1),
    .fs_dab   (fs_dab),
    .phi_quot (phi_quot),
    .phi_done (phi_done)
  );

  angle_combiner u_comb (
    .clk       (clk),
    .arst_n    (arst_n),
    .tau_quot  (tau_quot),
    .tau_done  (tau_done),
    .phi_quot  (phi_quot),
    .phi_done  (phi_done),
    .tau2      (tau2),
    .phi_2b    (phi_2b),
    .phi_2a    (phi_2a),
    .out_valid (out_valid)
  );

endmodule

/* bench/dab_modulator_tb.sv */
`timescale 1ns/1ps
`include "dab_settings.svh"

module dab_modulator_tb;

  localparam int AW      = `DAB_ANG_W;
  localparam int QB      = `DAB_QUOT_BITS;
  localparam int LAT     = `DAB_LATENCY;
  localparam int N_TRIG  = 52;                              // 40 random + 12 directed
  localparam int TIMEOUT = N_TRIG * (LAT + 4) + 100;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            trigger;
  dab_pkg::vin_t   vdc1;
  dab_pkg::vin_t   vdc2;
  dab_pkg::fs_t    fs_dab;
  dab_pkg::angle_t tau2;
  dab_pkg::angle_t phi_2b;
  dab_pkg::angle_t phi_2a;
  logic            out_valid;

  int              seed;
  int              cyc = 0;                                 // posedge count
  logic [3*AW-1:0] exp_q[$];                                // {tau2, phi_2b, phi_2a}
  int              trig_q[$];                               // sampling edge of trigger

  always #4 clk = ~clk;                                     // 8 ns period

  dab_modulator dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .trigger   (trigger),
    .vdc1      (vdc1),
    .vdc2      (vdc2),
    .fs_dab    (fs_dab),
    .tau2      (tau2),
    .phi_2b    (phi_2b),
    .phi_2a    (phi_2a),
    .out_valid (out_valid)
  );

  ////////////////////////////// reference model
  function automatic longint clamp_quot(input longint q);
    longint qmax;
    qmax = (longint'(1) << QB) - 1;
    if (q > qmax)
      q = qmax;
    else if (q < -qmax)
      q = -qmax;
    return q;
  endfunction

  function automatic logic [AW-1:0] round_angle(input longint q);
    longint mag;
    longint r;
    mag = (q < 0) ? -q : q;
    r   = (mag + (1 << (`DAB_FRAC_BITS - 1))) / (1 << `DAB_FRAC_BITS);  // half away from zero
    if (r > `DAB_OUT_MAX)
      r = `DAB_OUT_MAX;
    if (q < 0)
      r = -r;
    return r[AW-1:0];
  endfunction

  function automatic logic [3*AW-1:0] expected_angles(input int v1, input int v2, input int fs);
    longint tau_num;
    longint tau_den;
    longint phi_num;
    longint phi_den;
    longint tau_q;
    longint phi_q;
    tau_num = longint'(`DAB_K_TAU_V1) * v1 - longint'(`DAB_K_TAU_FS) * fs;
    tau_den = longint'(`DAB_K_TAU_V2) * v2;
    phi_num = -(longint'(`DAB_K_PHI_FS) * fs);
    phi_den = longint'(`DAB_K_PHI_V1) * v1;
    tau_q   = clamp_quot(tau_num / tau_den);                // sv division truncates to zero
    phi_q   = clamp_quot(phi_num / phi_den);
    return {round_angle(tau_q), round_angle(tau_q / 2), round_angle(phi_q)};
  endfunction

  ////////////////////////////// helpers
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [AW-1:0] exp_v,
                             input logic [AW-1:0] act_v);
    assert (act_v === exp_v)
    else
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp_v, act_v));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                                     // drive point
  endtask

  task automatic random_in_range(input int lo, input int hi, output int v);
    v = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endtask

  task automatic apply_trigger(input int v1, input int v2, input int fs, input bit accepted);
    trigger = 1'b1;
    vdc1    = dab_pkg::vin_t'(v1);
    vdc2    = dab_pkg::vin_t'(v2);
    fs_dab  = dab_pkg::fs_t'(fs);
    if (accepted)
    begin
      exp_q.push_back(expected_angles(v1, v2, fs));
      trig_q.push_back(cyc + 1);                            // sampled on the next edge
    end
    next_cycle();
    trigger = 1'b0;
  endtask

  task automatic wait_for_result();
    do
      next_cycle();
    while (!out_valid);
  endtask

  task automatic run_one(input int v1, input int v2, input int fs);
    apply_trigger(v1, v2, fs, 1'b1);
    wait_for_result();
    next_cycle();
  endtask

  ////////////////////////////// timeout
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT)
      abort_run($sformatf("timeout after %0d cycles, results did not arrive", cyc));
  end

  ////////////////////////////// compare
  always @(negedge clk)
  begin : compare_results
    logic [3*AW-1:0] exp_v;
    int              trig_cyc;
    if (arst_n === 1'b1 && out_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
        abort_run("out_valid pulsed with no accepted trigger pending");
      else
      begin
        exp_v    = exp_q.pop_front();
        trig_cyc = trig_q.pop_front();
        if (cyc - trig_cyc != LAT)
          abort_run($sformatf("result came %0d cycles after its trigger instead of %0d",
                              cyc - trig_cyc, LAT));
        else
        begin
          check_value("tau2", exp_v[3*AW-1:2*AW], tau2);
          check_value("phi_2b", exp_v[2*AW-1:AW], phi_2b);
          check_value("phi_2a", exp_v[AW-1:0], phi_2a);
        end
      end
    end
  end

  ////////////////////////////// stimulus
  initial
  begin : stimulus
    int v1;
    int v2;
    int fs;
    seed    = 32'hfee4;
    arst_n  = 1'b0;
    trigger = 1'b0;
    vdc1    = '0;
    vdc2    = '0;
    fs_dab  = '0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;

    repeat (10)                                             // idle after reset
    begin
      next_cycle();
      check_value("out_valid", '0, out_valid);
      check_value("tau2", '0, tau2);
      check_value("phi_2b", '0, phi_2b);
      check_value("phi_2a", '0, phi_2a);
    end

    for (int i = 0; i < 40; i++)                            // random nominal points
    begin
      random_in_range(800, 8191, v1);
      random_in_range(600, 6000, v2);
      random_in_range(10000, 150000, fs);
      run_one(v1, v2, fs);
    end

    run_one(1, 1, 262143);                                  // both clamp negative
    run_one(8191, 1, 10000);                                // tau2 clamps positive
    run_one(5, 3, -200000);                                 // phi_2a clamps positive

    run_one(10, 130, 102);                                  // tau q 56, phi q -40
    run_one(10, 151, 102);                                  // tau q 48, halved 24
    run_one(10, 10, 6568);                                  // tau q -56
    run_one(10, 10, 6500);                                  // tau q -48, halved -24
    run_one(10, 130, -102);                                 // phi q +40

    apply_trigger(3000, 600, 100000, 1'b1);                 // busy drop case
    repeat (4) next_cycle();
    apply_trigger(5000, 900, 50000, 1'b0);                  // lands 5 edges later
    wait_for_result();
    repeat (10) next_cycle();                               // a second pulse would show here

    apply_trigger(2500, 700, 80000, 1'b1);                  // back to back
    wait_for_result();
    apply_trigger(6000, 1200, 120000, 1'b1);                // during out_valid
    wait_for_result();
    next_cycle();

    repeat (30) next_cycle();
    if (exp_q.size() == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      abort_run($sformatf("%0d expected results never arrived", exp_q.size()));
  end

endmodule

/* list.f */
+incdir+src
src/dab_pkg.sv
src/serial_divider.sv
src/duty_branch.sv
src/phase_branch.sv
src/angle_combiner.sv
src/dab_modulator.sv
bench/dab_modulator_tb.sv
